// ==== hdl/lc3Isa.sv ====
package lc3Isa;

	localparam int wordBits = 16;
	localparam int ledBits = 12; // PAUSE shows IR[11:0]

	// Instruction field positions
	localparam int opLsb = 12;
	localparam int drLsb = 9; // Also the nzp mask of BR
	localparam int sr1Lsb = 6;
	localparam int sr2Lsb = 0;
	localparam int immFlagBit = 5;
	localparam int imm5Bits = 5;
	localparam int off6Bits = 6;
	localparam int off9Bits = 9;
	localparam int off11Bits = 11;

	typedef logic [wordBits-1:0] wordT;

	typedef enum logic [3:0] {
		opBr = 4'd0,
		opAdd = 4'd1,
		opJsr = 4'd4,
		opAnd = 4'd5,
		opLdr = 4'd6,
		opStr = 4'd7,
		opNot = 4'd9,
		opJmp = 4'd12,
		opPause = 4'd13
	} opcodeT;

	typedef enum logic [1:0] {
		aluAdd = 2'b00,
		aluAnd = 2'b01,
		aluNot = 2'b10,
		aluPassA = 2'b11
	} aluOpT;

	typedef struct packed {
		logic n;
		logic z;
		logic p;
	} ccT;

	typedef struct packed {
		wordT addr;
		wordT wData;
		logic rdEn;
		logic wrEn;
	} memReqT;

endpackage

// ==== hdl/lc3Ctrl.sv ====
package lc3Ctrl;

	typedef enum logic [4:0] {
		sHalted,
		sFetch, // PC to MAR, PC + 1
		sFetchWait1,
		sFetchWait2,
		sFetchWait3,
		sIrLoad,
		sDecode,
		sBr,
		sBrTaken,
		sAdd,
		sAnd,
		sNot,
		sJsrLink,
		sJsrPc,
		sJmp,
		sLdrAddr,
		sLdrWait1,
		sLdrWait2,
		sLdrWait3,
		sLdrWrite,
		sStrAddr,
		sStrMdr,
		sStrWait1,
		sStrWait2,
		sStrWait3,
		sPause1,
		sPause2
	} seqStateT;

	typedef enum logic [1:0] {
		pcInc = 2'b00,
		pcBus = 2'b01,
		pcAdder = 2'b10
	} pcSelT;

	typedef enum logic [1:0] {
		addrZero = 2'b00,
		addrOff6 = 2'b01,
		addrOff9 = 2'b10,
		addrOff11 = 2'b11
	} addr2SelT;

	typedef struct packed {
		logic ldMar;
		logic ldMdr;
		logic ldIr;
		logic ldBen;
		logic ldCc;
		logic ldReg;
		logic ldPc;
		logic ldLed;
		logic gatePc;
		logic gateMdr;
		logic gateAlu;
		logic gateAdder;
		pcSelT pcSel;
		logic drSel; // 1 selects R7
		logic sr1Sel; // 1 selects IR[8:6], else IR[11:9]
		logic addr1Sel; // 1 selects SR1, else PC
		addr2SelT addr2Sel;
		lc3Isa::aluOpT aluOp;
		logic memRd;
		logic memWr;
	} ctrlWordT;

endpackage

// ==== hdl/instrSequencer.sv ====
`timescale 1ns/1ps

module instrSequencer (
	input logic Clk,
	input logic rstN,
	input logic run,
	input logic continueRun,
	input lc3Isa::opcodeT opcode,
	input logic ben,
	output lc3Ctrl::ctrlWordT ctrl,
	output logic halted,
	output logic paused
);

	lc3Ctrl::seqStateT state, nextState;

	always_ff @(posedge Clk)
	begin
		if (!rstN)
			state <= lc3Ctrl::sHalted;
		else
			state <= nextState;
	end

	assign halted = (state == lc3Ctrl::sHalted);
	assign paused = (state == lc3Ctrl::sPause1) || (state == lc3Ctrl::sPause2);

	always_comb
	begin
		nextState = state;
		unique case (state)
			lc3Ctrl::sHalted: if (run) nextState = lc3Ctrl::sFetch;
			lc3Ctrl::sFetch: nextState = lc3Ctrl::sFetchWait1;
			lc3Ctrl::sFetchWait1: nextState = lc3Ctrl::sFetchWait2;
			lc3Ctrl::sFetchWait2: nextState = lc3Ctrl::sFetchWait3;
			lc3Ctrl::sFetchWait3: nextState = lc3Ctrl::sIrLoad;
			lc3Ctrl::sIrLoad: nextState = lc3Ctrl::sDecode;
			lc3Ctrl::sDecode:
			begin
				case (opcode)
					lc3Isa::opBr: nextState = lc3Ctrl::sBr;
					lc3Isa::opAdd: nextState = lc3Ctrl::sAdd;
					lc3Isa::opJsr: nextState = lc3Ctrl::sJsrLink;
					lc3Isa::opAnd: nextState = lc3Ctrl::sAnd;
					lc3Isa::opLdr: nextState = lc3Ctrl::sLdrAddr;
					lc3Isa::opStr: nextState = lc3Ctrl::sStrAddr;
					lc3Isa::opNot: nextState = lc3Ctrl::sNot;
					lc3Isa::opJmp: nextState = lc3Ctrl::sJmp;
					lc3Isa::opPause: nextState = lc3Ctrl::sPause1;
					default: nextState = lc3Ctrl::sFetch; // Unused codes act as no-ops
				endcase
			end
			lc3Ctrl::sBr: nextState = ben ? lc3Ctrl::sBrTaken : lc3Ctrl::sFetch;
			lc3Ctrl::sJsrLink: nextState = lc3Ctrl::sJsrPc;
			lc3Ctrl::sLdrAddr: nextState = lc3Ctrl::sLdrWait1;
			lc3Ctrl::sLdrWait1: nextState = lc3Ctrl::sLdrWait2;
			lc3Ctrl::sLdrWait2: nextState = lc3Ctrl::sLdrWait3;
			lc3Ctrl::sLdrWait3: nextState = lc3Ctrl::sLdrWrite;
			lc3Ctrl::sStrAddr: nextState = lc3Ctrl::sStrMdr;
			lc3Ctrl::sStrMdr: nextState = lc3Ctrl::sStrWait1;
			lc3Ctrl::sStrWait1: nextState = lc3Ctrl::sStrWait2;
			lc3Ctrl::sStrWait2: nextState = lc3Ctrl::sStrWait3;
			// Continue must go high, then low again
			lc3Ctrl::sPause1: if (continueRun) nextState = lc3Ctrl::sPause2;
			lc3Ctrl::sPause2: if (!continueRun) nextState = lc3Ctrl::sFetch;
			default: nextState = lc3Ctrl::sFetch; // Single-cycle execute states
		endcase
	end

	always_comb
	begin
		ctrl = '0;
		case (state)
			lc3Ctrl::sFetch:
			begin
				ctrl.gatePc = 1'b1;
				ctrl.ldMar = 1'b1;
				ctrl.ldPc = 1'b1;
				ctrl.pcSel = lc3Ctrl::pcInc;
			end
			lc3Ctrl::sFetchWait1, lc3Ctrl::sFetchWait2, lc3Ctrl::sFetchWait3,
			lc3Ctrl::sLdrWait1, lc3Ctrl::sLdrWait2, lc3Ctrl::sLdrWait3:
			begin
				ctrl.memRd = 1'b1;
				ctrl.ldMdr = 1'b1;
			end
			lc3Ctrl::sIrLoad:
			begin
				ctrl.gateMdr = 1'b1;
				ctrl.ldIr = 1'b1;
			end
			lc3Ctrl::sDecode: ctrl.ldBen = 1'b1;
			lc3Ctrl::sBrTaken:
			begin
				ctrl.ldPc = 1'b1;
				ctrl.pcSel = lc3Ctrl::pcAdder;
				ctrl.addr2Sel = lc3Ctrl::addrOff9;
			end
			lc3Ctrl::sAdd, lc3Ctrl::sAnd, lc3Ctrl::sNot:
			begin
				ctrl.sr1Sel = 1'b1;
				ctrl.gateAlu = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
				if (state == lc3Ctrl::sAnd)
					ctrl.aluOp = lc3Isa::aluAnd;
				else if (state == lc3Ctrl::sNot)
					ctrl.aluOp = lc3Isa::aluNot;
				else
					ctrl.aluOp = lc3Isa::aluAdd;
			end
			lc3Ctrl::sJsrLink:
			begin
				ctrl.gatePc = 1'b1; // Incremented PC into R7
				ctrl.drSel = 1'b1;
				ctrl.ldReg = 1'b1;
			end
			lc3Ctrl::sJsrPc:
			begin
				ctrl.ldPc = 1'b1;
				ctrl.pcSel = lc3Ctrl::pcAdder;
				ctrl.addr2Sel = lc3Ctrl::addrOff11;
			end
			lc3Ctrl::sJmp:
			begin
				ctrl.ldPc = 1'b1;
				ctrl.pcSel = lc3Ctrl::pcAdder;
				ctrl.sr1Sel = 1'b1;
				ctrl.addr1Sel = 1'b1;
				ctrl.addr2Sel = lc3Ctrl::addrZero;
			end
			lc3Ctrl::sLdrAddr, lc3Ctrl::sStrAddr:
			begin
				ctrl.ldMar = 1'b1;
				ctrl.gateAdder = 1'b1;
				ctrl.sr1Sel = 1'b1; // BaseR
				ctrl.addr1Sel = 1'b1;
				ctrl.addr2Sel = lc3Ctrl::addrOff6;
			end
			lc3Ctrl::sLdrWrite:
			begin
				ctrl.gateMdr = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
			end
			lc3Ctrl::sStrMdr:
			begin
				ctrl.aluOp = lc3Isa::aluPassA; // SR from IR[11:9]
				ctrl.gateAlu = 1'b1;
				ctrl.ldMdr = 1'b1;
			end
			lc3Ctrl::sStrWait1, lc3Ctrl::sStrWait2, lc3Ctrl::sStrWait3: ctrl.memWr = 1'b1;
			lc3Ctrl::sPause1, lc3Ctrl::sPause2: ctrl.ldLed = 1'b1;
			default: ;
		endcase
	end

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input logic Clk,
	input logic rstN,
	input logic we,
	input logic [2:0] wAddr,
	input logic [2:0] rAddr1,
	input logic [2:0] rAddr2,
	input lc3Isa::wordT wData,
	output lc3Isa::wordT rData1,
	output lc3Isa::wordT rData2
);

	lc3Isa::wordT regs [8];

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else if (we)
			regs[wAddr] <= wData;
	end

	// Reads are combinational
	assign rData1 = regs[rAddr1];
	assign rData2 = regs[rAddr2];

endmodule

// ==== hdl/dataPath.sv ====
`timescale 1ns/1ps

module dataPath (
	input logic Clk,
	input logic rstN,
	input lc3Ctrl::ctrlWordT ctrl,
	input lc3Isa::wordT rData,
	output lc3Isa::opcodeT opcode,
	output logic ben,
	output lc3Isa::memReqT memReq,
	output logic [lc3Isa::ledBits-1:0] led
);

	localparam int msb = lc3Isa::wordBits - 1;

	lc3Isa::wordT pc, pcNext, mar, mdr, ir;
	lc3Isa::wordT bus, aluOut, aluB, adderOut, addr1, addr2;
	lc3Isa::wordT sr1Data, sr2Data;
	lc3Isa::ccT cc;
	logic [2:0] sr1Addr, drAddr;

	assign sr1Addr = ctrl.sr1Sel ? ir[lc3Isa::sr1Lsb +: 3] : ir[lc3Isa::drLsb +: 3];
	assign drAddr = ctrl.drSel ? 3'd7 : ir[lc3Isa::drLsb +: 3];

	regFile regs (
		.Clk(Clk),
		.rstN(rstN),
		.we(ctrl.ldReg),
		.wAddr(drAddr),
		.rAddr1(sr1Addr),
		.rAddr2(ir[lc3Isa::sr2Lsb +: 3]),
		.wData(bus),
		.rData1(sr1Data),
		.rData2(sr2Data)
	);

	// imm5 when IR[5] is set
	assign aluB = ir[lc3Isa::immFlagBit] ?
		{{(lc3Isa::wordBits - lc3Isa::imm5Bits){ir[lc3Isa::imm5Bits-1]}},
		ir[lc3Isa::imm5Bits-1:0]} : sr2Data;

	always_comb
	begin
		unique case (ctrl.aluOp)
			lc3Isa::aluAdd: aluOut = sr1Data + aluB;
			lc3Isa::aluAnd: aluOut = sr1Data & aluB;
			lc3Isa::aluNot: aluOut = ~sr1Data;
			default: aluOut = sr1Data;
		endcase
	end

	assign addr1 = ctrl.addr1Sel ? sr1Data : pc;

	always_comb
	begin
		unique case (ctrl.addr2Sel)
			lc3Ctrl::addrOff6:
				addr2 = {{(lc3Isa::wordBits - lc3Isa::off6Bits){ir[lc3Isa::off6Bits-1]}},
					ir[lc3Isa::off6Bits-1:0]};
			lc3Ctrl::addrOff9:
				addr2 = {{(lc3Isa::wordBits - lc3Isa::off9Bits){ir[lc3Isa::off9Bits-1]}},
					ir[lc3Isa::off9Bits-1:0]};
			lc3Ctrl::addrOff11:
				addr2 = {{(lc3Isa::wordBits - lc3Isa::off11Bits){ir[lc3Isa::off11Bits-1]}},
					ir[lc3Isa::off11Bits-1:0]};
			default: addr2 = '0;
		endcase
	end

	assign adderOut = addr1 + addr2;

	// Only one gate is active per state
	assign bus = ctrl.gatePc ? pc :
		ctrl.gateMdr ? mdr :
		ctrl.gateAlu ? aluOut :
		ctrl.gateAdder ? adderOut : '0;

	always_comb
	begin
		case (ctrl.pcSel)
			lc3Ctrl::pcInc: pcNext = pc + 1'b1;
			lc3Ctrl::pcBus: pcNext = bus;
			lc3Ctrl::pcAdder: pcNext = adderOut;
			default: pcNext = pc;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			pc <= '0;
			cc <= '0;
			ben <= 1'b0;
			led <= '0;
		end
		else
		begin
			if (ctrl.ldPc)
				pc <= pcNext;
			if (ctrl.ldCc)
				cc <= '{n: bus[msb], z: (bus == '0), p: !bus[msb] && (bus != '0)};
			if (ctrl.ldBen)
				ben <= |(ir[lc3Isa::drLsb +: 3] & cc);
			if (ctrl.ldLed)
				led <= ir[lc3Isa::ledBits-1:0];
		end
	end

	always_ff @(posedge Clk)
	begin
		if (ctrl.ldMar)
			mar <= bus;
		if (ctrl.ldMdr)
			mdr <= ctrl.memRd ? rData : bus;
		if (ctrl.ldIr)
			ir <= bus;
	end

	assign opcode = lc3Isa::opcodeT'(ir[lc3Isa::opLsb +: 4]);
	assign memReq = '{addr: mar, wData: mdr, rdEn: ctrl.memRd, wrEn: ctrl.memWr};

endmodule

// ==== hdl/syncRam.sv ====
`timescale 1ns/1ps

module syncRam #(
	parameter int memWords = 1024
) (
	input logic Clk,
	input lc3Isa::memReqT memReq,
	input lc3Isa::memReqT prog, // wrEn acts as the load strobe
	output lc3Isa::wordT rData
);

	localparam int addrBits = $clog2(memWords);

	lc3Isa::wordT mem [memWords];
	logic [addrBits-1:0] coreAddr, progAddr;

	assign coreAddr = memReq.addr[addrBits-1:0];
	assign progAddr = prog.addr[addrBits-1:0];

	always_ff @(posedge Clk)
	begin
		// Program load wins over the core
		if (prog.wrEn)
			mem[progAddr] <= prog.wData;
		else if (memReq.wrEn)
			mem[coreAddr] <= memReq.wData;
	end

	always_ff @(posedge Clk)
	begin
		if (memReq.rdEn)
			rData <= mem[coreAddr];
	end

endmodule

// ==== hdl/lc3Core.sv ====
`timescale 1ns/1ps

module lc3Core #(
	parameter int memWords = 1024
) (
	input logic Clk,
	input logic rstN,
	input logic run,
	input logic continueRun,
	input lc3Isa::memReqT prog,
	output logic halted,
	output logic paused,
	output logic [lc3Isa::ledBits-1:0] led,
	output lc3Isa::memReqT memReq
);

	lc3Ctrl::ctrlWordT ctrl;
	lc3Isa::opcodeT opcode;
	lc3Isa::wordT rData;
	logic ben;

	instrSequencer seq (
		.Clk(Clk),
		.rstN(rstN),
		.run(run),
		.continueRun(continueRun),
		.opcode(opcode),
		.ben(ben),
		.ctrl(ctrl),
		.halted(halted),
		.paused(paused)
	);

	dataPath dp (
		.Clk(Clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.rData(rData),
		.opcode(opcode),
		.ben(ben),
		.memReq(memReq),
		.led(led)
	);

	syncRam #(
		.memWords(memWords)
	) ram (
		.Clk(Clk),
		.memReq(memReq),
		.prog(prog),
		.rData(rData)
	);

endmodule

// ==== tests/lc3CoreTb.sv ====
`timescale 1ns/1ps

module lc3CoreTb;

	localparam int waitLimit = 400; // Cycles per wait
	localparam lc3Isa::wordT dataBase = 16'h0100; // Pointer word kept at address 31

	logic Clk, rstN, run, continueRun;
	logic halted, paused;
	logic [lc3Isa::ledBits-1:0] led;
	lc3Isa::memReqT prog, memReq;

	lc3Isa::wordT code[$];
	lc3Isa::memReqT dataWords[$];
	lc3Isa::memReqT expStores[$];
	logic [31:0] lfsrState;
	int testErrors, totalErrors, passedTests, failedTests;

	lc3Core #(
		.memWords(1024)
	) DUT (
		.Clk(Clk),
		.rstN(rstN),
		.run(run),
		.continueRun(continueRun),
		.prog(prog),
		.halted(halted),
		.paused(paused),
		.led(led),
		.memReq(memReq)
	);

	always #5 Clk = ~Clk;

	function automatic logic lfsrStep();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
			lfsrState = lfsrState ^ 32'h80200003;
		return outBit;
	endfunction

	function automatic lc3Isa::wordT randBits(input int n);
		lc3Isa::wordT w;
		w = '0;
		for (int i = 0; i < n; i++)
			w = {w[14:0], lfsrStep()};
		return w;
	endfunction

	// Formats with two register fields and a 6-bit tail
	function automatic lc3Isa::wordT encode(input lc3Isa::opcodeT op, input logic [2:0] a,
		input logic [2:0] b, input logic [5:0] low6);
		return {op, a, b, low6};
	endfunction

	task automatic reportMismatch(input string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		testErrors++;
	endtask

	task automatic reportProblem(input string msg);
		$display("%s", msg);
		testErrors++;
	endtask

	task automatic checkStore(input lc3Isa::memReqT got, input lc3Isa::memReqT exp);
		if (got.addr !== exp.addr || got.wData !== exp.wData)
			reportMismatch($sformatf("store to %h of %h, expected %h to %h",
				got.addr, got.wData, exp.wData, exp.addr));
	endtask

	task automatic checkLed(input logic [lc3Isa::ledBits-1:0] got,
		input logic [lc3Isa::ledBits-1:0] exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic addData(input lc3Isa::wordT addr, input lc3Isa::wordT data);
		dataWords.push_back('{addr: addr, wData: data, rdEn: 1'b0, wrEn: 1'b1});
	endtask

	task automatic addExpected(input lc3Isa::wordT addr, input lc3Isa::wordT data);
		expStores.push_back('{addr: addr, wData: data, rdEn: 1'b0, wrEn: 1'b1});
	endtask

	task automatic beginTest();
		@(posedge Clk);
		rstN <= 1'b0;
		run <= 1'b0;
		continueRun <= 1'b0;
		prog <= '0;
		repeat (5) @(posedge Clk);
		rstN <= 1'b1;
		code.delete();
		dataWords.delete();
		expStores.delete();
		testErrors = 0;
		addData(16'd31, dataBase);
	endtask

	task automatic endTest(input string name);
		totalErrors += testErrors;
		if (testErrors == 0)
		begin
			passedTests++;
			$display("%s: passed", name);
		end
		else
		begin
			failedTests++;
			$display("%s: failed with %0d errors", name, testErrors);
		end
	endtask

	task automatic loadWord(input lc3Isa::wordT addr, input lc3Isa::wordT data);
		@(posedge Clk);
		prog <= '{addr: addr, wData: data, rdEn: 1'b0, wrEn: 1'b1};
	endtask

	task automatic loadProgram(); // Only while halted
		foreach (code[i])
			loadWord(16'(i), code[i]);
		foreach (dataWords[i])
			loadWord(dataWords[i].addr, dataWords[i].wData);
		@(posedge Clk);
		prog <= '0;
	endtask

	task automatic startRun();
		@(posedge Clk);
		run <= 1'b1;
		@(posedge Clk);
		run <= 1'b0;
	endtask

	task automatic waitStore(output lc3Isa::memReqT got);
		int n;
		n = 0;
		got = '0;
		@(negedge Clk);
		while (memReq.wrEn && n < waitLimit) // Let the previous store end
		begin
			@(negedge Clk);
			n++;
		end
		while (!memReq.wrEn && n < waitLimit)
		begin
			@(negedge Clk);
			n++;
		end
		if (memReq.wrEn)
			got = memReq;
		else
			reportProblem("Timed out waiting for a store from the core");
	endtask

	task automatic waitPause();
		int n;
		n = 0;
		@(negedge Clk);
		while (!paused && n < waitLimit)
		begin
			@(negedge Clk);
			n++;
		end
		if (!paused)
			reportProblem("Timed out waiting for the core to reach PAUSE");
	endtask

	task automatic runAndCheck();
		lc3Isa::memReqT got;
		loadProgram();
		startRun();
		foreach (expStores[i])
		begin
			waitStore(got);
			checkStore(got, expStores[i]);
		end
		waitPause();
	endtask

	task automatic resetHaltTest();
		int cycles;
		beginTest();
		@(negedge Clk);
		checkFlag(halted, 1'b1, "halted after reset");
		checkFlag(memReq.wrEn, 1'b0, "wrEn after reset");
		checkFlag(memReq.rdEn, 1'b0, "rdEn after reset");
		checkLed(led, '0, "led after reset");
		code.push_back({lc3Isa::opPause, 12'h123});
		loadProgram();
		@(posedge Clk);
		run <= 1'b1;
		cycles = 0;
		@(negedge Clk);
		while (!memReq.rdEn && cycles < waitLimit)
		begin
			@(posedge Clk);
			run <= 1'b0;
			cycles++;
			@(negedge Clk);
		end
		if (cycles != 2)
			reportMismatch($sformatf("first read %0d cycles after run, expected 2", cycles));
		checkFlag(halted, 1'b0, "halted while running");
		waitPause();
		endTest("reset and halt");
	endtask

	task automatic arithmeticTest();
		lc3Isa::wordT a, b, immExt;
		logic [4:0] imm;
		beginTest();
		a = randBits(16);
		b = randBits(16);
		imm = 5'(randBits(5));
		immExt = {{11{imm[4]}}, imm};
		addData(dataBase, a);
		addData(dataBase + 16'd1, b);
		code.push_back(encode(lc3Isa::opLdr, 3'd6, 3'd0, 6'd31));
		code.push_back(encode(lc3Isa::opLdr, 3'd1, 3'd6, 6'd0));
		code.push_back(encode(lc3Isa::opLdr, 3'd2, 3'd6, 6'd1));
		code.push_back(encode(lc3Isa::opAdd, 3'd3, 3'd1, 6'd2));
		code.push_back(encode(lc3Isa::opStr, 3'd3, 3'd6, 6'd16));
		code.push_back(encode(lc3Isa::opAnd, 3'd3, 3'd1, 6'd2));
		code.push_back(encode(lc3Isa::opStr, 3'd3, 3'd6, 6'd17));
		code.push_back(encode(lc3Isa::opAdd, 3'd3, 3'd1, {1'b1, imm}));
		code.push_back(encode(lc3Isa::opStr, 3'd3, 3'd6, 6'd18));
		code.push_back(encode(lc3Isa::opAnd, 3'd3, 3'd1, {1'b1, imm}));
		code.push_back(encode(lc3Isa::opStr, 3'd3, 3'd6, 6'd19));
		code.push_back(encode(lc3Isa::opNot, 3'd3, 3'd1, 6'h3f));
		code.push_back(encode(lc3Isa::opStr, 3'd3, 3'd6, 6'd20));
		code.push_back({lc3Isa::opPause, 12'h000});
		addExpected(dataBase + 16'd16, a + b);
		addExpected(dataBase + 16'd17, a & b);
		addExpected(dataBase + 16'd18, a + immExt);
		addExpected(dataBase + 16'd19, a & immExt);
		addExpected(dataBase + 16'd20, ~a);
		runAndCheck();
		endTest("arithmetic");
	endtask

	task automatic branchTest();
		lc3Isa::wordT marker;
		logic [4:0] imm;
		logic [2:0] mask, cc;
		beginTest();
		marker = randBits(16);
		addData(dataBase, marker);
		code.push_back(encode(lc3Isa::opLdr, 3'd6, 3'd0, 6'd31));
		code.push_back(encode(lc3Isa::opLdr, 3'd5, 3'd6, 6'd0));
		for (int i = 0; i < 6; i++)
		begin
			if (i % 3 == 0)
			begin
				imm = {1'b1, 4'(randBits(4))}; // Negative
				cc = 3'b100;
			end
			else if (i % 3 == 1)
			begin
				imm = 5'd0;
				cc = 3'b010;
			end
			else
			begin
				imm = {1'b0, 4'(randBits(4))} | 5'd1;
				cc = 3'b001;
			end
			mask = 3'(randBits(3));
			code.push_back(encode(lc3Isa::opAdd, 3'd2, 3'd0, {1'b1, imm}));
			code.push_back({lc3Isa::opBr, mask, 9'd1}); // Taken skips the store
			code.push_back(encode(lc3Isa::opStr, 3'd5, 3'd6, 6'(16 + i)));
			if ((mask & cc) == 3'b000)
				addExpected(dataBase + 16'(16 + i), marker);
		end
		code.push_back(encode(lc3Isa::opStr, 3'd5, 3'd6, 6'd31));
		code.push_back({lc3Isa::opPause, 12'h000});
		addExpected(dataBase + 16'd31, marker);
		runAndCheck();
		endTest("branches");
	endtask

	task automatic jsrJmpTest();
		lc3Isa::wordT marker, linkAddr, target;
		beginTest();
		marker = randBits(16);
		addData(dataBase, marker);
		code.push_back(encode(lc3Isa::opLdr, 3'd6, 3'd0, 6'd31));
		code.push_back(encode(lc3Isa::opLdr, 3'd5, 3'd6, 6'd0));
		linkAddr = 16'(code.size() + 1);
		code.push_back({lc3Isa::opJsr, 1'b1, 11'd2});
		code.push_back(encode(lc3Isa::opStr, 3'd5, 3'd6, 6'd20));
		code.push_back(encode(lc3Isa::opStr, 3'd5, 3'd6, 6'd21));
		code.push_back(encode(lc3Isa::opStr, 3'd7, 3'd6, 6'd16));
		target = 16'(code.size() + 4);
		addData(dataBase + 16'd1, target);
		code.push_back(encode(lc3Isa::opLdr, 3'd4, 3'd6, 6'd1));
		code.push_back(encode(lc3Isa::opJmp, 3'd0, 3'd4, 6'd0));
		code.push_back(encode(lc3Isa::opStr, 3'd5, 3'd6, 6'd22));
		code.push_back(encode(lc3Isa::opStr, 3'd5, 3'd6, 6'd23));
		code.push_back(encode(lc3Isa::opStr, 3'd5, 3'd6, 6'd17)); // JMP target
		code.push_back({lc3Isa::opPause, 12'h000});
		addExpected(dataBase + 16'd16, linkAddr);
		addExpected(dataBase + 16'd17, marker);
		runAndCheck();
		endTest("jsr and jmp");
	endtask

	task automatic roundTripTest();
		logic [5:0] offs[4];
		lc3Isa::wordT data;
		beginTest();
		code.push_back(encode(lc3Isa::opLdr, 3'd6, 3'd0, 6'd31));
		for (int i = 0; i < 4; i++)
		begin
			offs[i] = 6'(i * 4) | 6'(randBits(2));
			data = randBits(16);
			addData(dataBase + 16'(offs[i]), data);
			addExpected(dataBase + 16'(16 + i), data);
			code.push_back(encode(lc3Isa::opLdr, 3'(i + 1), 3'd6, offs[i]));
		end
		for (int i = 0; i < 4; i++)
			code.push_back(encode(lc3Isa::opStr, 3'(i + 1), 3'd6, 6'(16 + i)));
		code.push_back({lc3Isa::opPause, 12'h000});
		runAndCheck();
		endTest("load store round trip");
	endtask

	task automatic pauseTest();
		lc3Isa::wordT data;
		lc3Isa::memReqT got;
		logic [lc3Isa::ledBits-1:0] ledValue;
		beginTest();
		data = randBits(16);
		ledValue = 12'(randBits(12));
		addData(dataBase, data);
		addExpected(dataBase + 16'd16, data);
		code.push_back(encode(lc3Isa::opLdr, 3'd6, 3'd0, 6'd31));
		code.push_back(encode(lc3Isa::opLdr, 3'd1, 3'd6, 6'd0));
		code.push_back({lc3Isa::opPause, ledValue});
		code.push_back(encode(lc3Isa::opStr, 3'd1, 3'd6, 6'd16));
		code.push_back({lc3Isa::opPause, 12'h000});
		loadProgram();
		startRun();
		waitPause();
		@(negedge Clk); // led loads in the first pause cycle
		checkLed(led, ledValue, "led at first PAUSE");
		for (int i = 0; i < 12; i++)
		begin
			if (i == 6)
			begin
				@(posedge Clk);
				continueRun <= 1'b1;
			end
			@(negedge Clk);
			if (!paused || memReq.wrEn || memReq.rdEn)
				reportProblem("Core left PAUSE before continueRun went high and low");
		end
		@(posedge Clk);
		continueRun <= 1'b0;
		waitStore(got);
		checkStore(got, expStores[0]);
		waitPause();
		@(negedge Clk);
		checkLed(led, 12'h000, "led at second PAUSE");
		endTest("pause");
	endtask

	initial
	begin
		Clk = 1'b0;
		rstN = 1'b0;
		run = 1'b0;
		continueRun = 1'b0;
		prog = '0;
		lfsrState = 32'h3a90;
		totalErrors = 0;
		passedTests = 0;
		failedTests = 0;
		resetHaltTest();
		arithmeticTest();
		branchTest();
		jsrJmpTest();
		roundTripTest();
		pauseTest();
		$display("Tests: %0d passed, %0d failed, %0d errors", passedTests, failedTests,
			totalErrors);
		if (failedTests == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== lc3Core.f ====
hdl/lc3Isa.sv
hdl/lc3Ctrl.sv
hdl/instrSequencer.sv
hdl/regFile.sv
hdl/dataPath.sv
hdl/syncRam.sv
hdl/lc3Core.sv
tests/lc3CoreTb.sv
